/* verilog/pe_cfg.svh */
`ifndef PE_CFG_SVH
`define PE_CFG_SVH

// ifmap row length in words
`define IF_LEN 12

// filter row length in words
`define FILT_LEN 4

// ifmap and filter words, signed
`define DATA_W 8

// partial sums, signed
`define PSUM_W 24

// largest supported stride
`define MAX_STRIDE 3

`endif

/* verilog/pe_pkg.sv */
`include "pe_cfg.svh"

package pe_pkg;

    typedef enum logic [1:0] {
        conv_row,
        conv_two_row,
        just_add
    } pe_mode_e;

    typedef logic signed [`DATA_W-1:0] data_t;
    typedef logic signed [`PSUM_W-1:0] psum_t;

    typedef logic [$clog2(`IF_LEN)-1:0]       idx_t;       // output index, psum address
    typedef logic [$clog2(2*`IF_LEN)-1:0]     if_addr_t;   // two ifmap rows
    typedef logic [$clog2(2*`FILT_LEN)-1:0]   filt_addr_t; // two filter rows
    typedef logic [$clog2(`MAX_STRIDE+1)-1:0] stride_t;

    typedef enum logic [1:0] {
        tgt_ifmap,
        tgt_filter,
        tgt_psum
    } load_tgt_e;

    typedef struct packed {
        load_tgt_e target;
        if_addr_t  addr;
        psum_t     data;   // low DATA_W bits for ifmap and filter
    } load_t;

    typedef struct packed {
        pe_mode_e mode;
        stride_t  stride;
    } pass_cfg_t;

    typedef struct packed {
        idx_t  index;
        psum_t value;
    } result_t;

endpackage

/* verilog/pe_controller.sv */
module pe_controller (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  pe_pkg::pass_cfg_t cfg,
    input  logic              stride_count_flag,
    input  logic              psum_done,
    input  logic              stride_pos_ld,
    input  logic              full_done,
    output logic              reset_all,
    output logic              if_read_start,
    output logic              filter_read_start,
    output logic              start_rd_gen,
    output logic              clear_regs,
    output logic              reset_filter,
    output logic              row_sel,
    output logic              done
);
    import pe_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_fetch,
        s_dispatch,
        s_conv_row,
        s_conv_two_row_1,
        s_conv_two_row_2,
        s_just_add
    } state_e;

    state_e   state;
    state_e   next_state;
    pe_mode_e mode_q;
    logic     in_pass;
    logic     row_end;

    assign in_pass = state inside {s_conv_row, s_conv_two_row_1, s_conv_two_row_2, s_just_add};
    assign row_end = stride_pos_ld && stride_count_flag; // last tap of the row's last output

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= s_idle;
            mode_q <= conv_row;
            done   <= 1'b0;
        end else begin
            state <= next_state;
            done  <= in_pass && full_done;
            if (start && state == s_idle) begin
                mode_q <= cfg.mode;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            s_idle: begin
                if (start) next_state = s_fetch;
            end
            s_fetch:    next_state = s_dispatch;
            s_dispatch: begin
                case (mode_q)
                    conv_two_row: next_state = s_conv_two_row_1;
                    just_add:     next_state = s_just_add;
                    default:      next_state = s_conv_row;
                endcase
            end
            s_conv_two_row_1: begin
                if (row_end) next_state = s_conv_two_row_2;
            end
            s_conv_row, s_conv_two_row_2, s_just_add: begin
                if (full_done) next_state = s_idle;
            end
            default:    next_state = s_idle;
        endcase
    end

    always_comb begin
        reset_all         = 1'b0;
        if_read_start     = 1'b0;
        filter_read_start = 1'b0;
        start_rd_gen      = 1'b0;
        clear_regs        = 1'b0;
        reset_filter      = 1'b0;
        row_sel           = 1'b0;
        case (state)
            s_idle:     reset_all = 1'b1;
            s_fetch: begin
                if_read_start     = 1'b1;
                filter_read_start = 1'b1;
            end
            s_dispatch: start_rd_gen = 1'b1;
            s_conv_two_row_1: begin
                clear_regs   = psum_done;
                reset_filter = row_end;   // rewind for row two
            end
            s_conv_two_row_2: begin
                clear_regs = psum_done;
                row_sel    = 1'b1;
            end
            s_conv_row, s_just_add: clear_regs = psum_done;
            default: ;
        endcase
    end

endmodule

/* verilog/scratchpad.sv */
module scratchpad #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  payload_t                 wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    // read returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];
    end

endmodule

/* verilog/addr_gen.sv */
`include "pe_cfg.svh"

module addr_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               reset_all,
    input  logic               start_rd_gen,
    input  logic               reset_filter,
    input  logic               row_sel,
    input  pe_pkg::pe_mode_e   mode,
    input  pe_pkg::stride_t    stride,
    output pe_pkg::if_addr_t   if_addr,
    output pe_pkg::filt_addr_t filt_addr,
    output pe_pkg::idx_t       psum_addr,
    output logic               tap_valid,
    output logic               first_tap,
    output logic               last_tap,
    output pe_pkg::idx_t       index,
    output logic               stride_count_flag,
    output logic               psum_done,
    output logic               stride_pos_ld,
    output logic               full_done
);
    import pe_pkg::*;

    localparam int IF_LEN   = `IF_LEN;
    localparam int FILT_LEN = `FILT_LEN;
    localparam int TAP_W    = $clog2(FILT_LEN);

    logic             active;
    logic [TAP_W-1:0] tap_cnt;
    idx_t             out_cnt;
    idx_t             last_out;
    logic             tap_last;
    logic             pass_end;
    logic             pass_end_d;

    // index of the last output in a row
    always_comb begin
        last_out = idx_t'(IF_LEN - FILT_LEN);
        for (int s = 2; s <= `MAX_STRIDE; s++) begin
            if (int'(stride) == s) last_out = idx_t'((IF_LEN - FILT_LEN) / s);
        end
        if (mode == just_add) last_out = idx_t'(IF_LEN - 1);
    end

    assign tap_last          = (mode == just_add) || (tap_cnt == TAP_W'(FILT_LEN - 1));
    assign stride_count_flag = active && tap_last;
    assign stride_pos_ld     = active && (out_cnt == last_out);
    assign pass_end = stride_count_flag && stride_pos_ld && (mode != conv_two_row || row_sel);

    always_comb begin
        if (mode == just_add) begin
            if_addr   = if_addr_t'(out_cnt);
            filt_addr = filt_addr_t'(out_cnt);
        end else begin
            if_addr   = if_addr_t'(out_cnt) * if_addr_t'(stride) + if_addr_t'(tap_cnt);
            filt_addr = filt_addr_t'(tap_cnt);
            if (row_sel) begin
                if_addr   = if_addr + if_addr_t'(IF_LEN);
                filt_addr = filt_addr + filt_addr_t'(FILT_LEN);
            end
        end
    end

    assign psum_addr = out_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active  <= 1'b0;
            tap_cnt <= '0;
            out_cnt <= '0;
        end else if (reset_all || start_rd_gen) begin
            active  <= start_rd_gen;
            tap_cnt <= '0;
            out_cnt <= '0;
        end else if (active) begin
            if (reset_filter || pass_end) begin
                active  <= !pass_end;
                tap_cnt <= '0;
                out_cnt <= '0;
            end else if (stride_count_flag) begin
                tap_cnt <= '0;
                out_cnt <= out_cnt + 1'b1;
            end else begin
                tap_cnt <= tap_cnt + 1'b1;
            end
        end
    end

    // tap markers follow the registered scratchpad reads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_valid  <= 1'b0;
            first_tap  <= 1'b0;
            last_tap   <= 1'b0;
            pass_end_d <= 1'b0;
            full_done  <= 1'b0;
        end else begin
            tap_valid  <= active;
            first_tap  <= active && (tap_cnt == '0);
            last_tap   <= stride_count_flag;
            pass_end_d <= pass_end;
            full_done  <= pass_end_d;   // final result now in the output register
        end
    end

    always_ff @(posedge clk) begin
        index <= out_cnt;
    end

    assign psum_done = last_tap;

endmodule

/* verilog/mac_unit.sv */
module mac_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear_regs,
    input  logic             tap_valid,
    input  logic             first_tap,
    input  logic             last_tap,
    input  pe_pkg::idx_t     index,
    input  pe_pkg::pe_mode_e mode,
    input  logic             row_sel,
    input  pe_pkg::data_t    if_data,
    input  pe_pkg::data_t    filt_data,
    input  pe_pkg::psum_t    psum_rd,
    output logic             psum_we,
    output pe_pkg::idx_t     psum_wr_addr,
    output pe_pkg::psum_t    psum_wr_data,
    output logic             out_valid,
    output pe_pkg::result_t  out
);
    import pe_pkg::*;

    psum_t acc;
    psum_t prod;
    psum_t base;
    psum_t sum;
    logic  row_sel_d;   // row of the taps now at the read ports
    logic  finish;
    logic  hold_row;

    assign prod = psum_t'(if_data) * psum_t'(filt_data);
    assign base = !first_tap ? acc : (row_sel_d ? psum_rd : '0); // row two resumes row one
    assign sum  = (mode == just_add) ? psum_rd + psum_t'(if_data) : base + prod;

    assign finish   = tap_valid && last_tap;
    assign hold_row = (mode == conv_two_row) && !row_sel_d;  // row one sums stay local

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            row_sel_d <= 1'b0;
            out_valid <= 1'b0;
            psum_we   <= 1'b0;
        end else begin
            row_sel_d <= row_sel;
            out_valid <= finish && !hold_row;
            psum_we   <= finish && hold_row;
        end
    end

    always_ff @(posedge clk) begin
        if (clear_regs) begin
            acc <= '0;
        end else if (tap_valid) begin
            acc <= sum;
        end
        if (finish) begin
            out.index    <= index;
            out.value    <= sum;
            psum_wr_addr <= index;
            psum_wr_data <= sum;
        end
    end

endmodule

/* verilog/conv_pe.sv */
`include "pe_cfg.svh"

module conv_pe (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_en,
    input  pe_pkg::load_t     load,
    input  logic              start,
    input  pe_pkg::pass_cfg_t cfg,
    output logic              out_valid,
    output pe_pkg::result_t   out,
    output logic              done
);
    import pe_pkg::*;

    localparam int IF_LEN   = `IF_LEN;
    localparam int FILT_LEN = `FILT_LEN;

    // controller strobes
    logic reset_all, if_read_start, filter_read_start, start_rd_gen;
    logic clear_regs, reset_filter, row_sel;

    // loop flags back from addr_gen
    logic stride_count_flag, psum_done, stride_pos_ld, full_done;

    if_addr_t   if_addr;
    filt_addr_t filt_addr;
    idx_t       psum_addr;
    logic       tap_valid, first_tap, last_tap;
    idx_t       index;

    pe_mode_e   mode;
    stride_t    stride;

    data_t      if_data;
    data_t      filt_data;
    psum_t      psum_rd;
    logic       psum_we;
    idx_t       psum_wr_addr;
    psum_t      psum_wr_data;

    logic       busy;       // pass in flight, psum port owned by the MAC
    logic       load_ok;
    logic       psum_wr_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode   <= conv_row;
            stride <= '0;
            busy   <= 1'b0;
        end else begin
            if (start && reset_all) begin   // same cycle the controller takes start
                mode   <= cfg.mode;
                stride <= cfg.stride;
            end
            if (if_read_start || filter_read_start) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    assign load_ok    = load_en && !busy;
    assign psum_wr_en = psum_we || (load_ok && load.target == tgt_psum);

    pe_controller i_ctrl (.*);

    addr_gen i_addr_gen (.*);

    mac_unit i_mac (.*);

    scratchpad #(.payload_t(data_t), .DEPTH(2 * IF_LEN)) ifmap_spad (
        .clk    (clk),
        .wr_en  (load_ok && load.target == tgt_ifmap),
        .wr_addr(load.addr),
        .wr_data(data_t'(load.data)),
        .rd_addr(if_addr),
        .rd_data(if_data)
    );

    scratchpad #(.payload_t(data_t), .DEPTH(2 * FILT_LEN)) filter_spad (
        .clk    (clk),
        .wr_en  (load_ok && load.target == tgt_filter),
        .wr_addr(filt_addr_t'(load.addr)),
        .wr_data(data_t'(load.data)),
        .rd_addr(filt_addr),
        .rd_data(filt_data)
    );

    // write port shared by outside loads and row-one writeback
    scratchpad #(.payload_t(psum_t), .DEPTH(IF_LEN)) psum_spad (
        .clk    (clk),
        .wr_en  (psum_wr_en),
        .wr_addr(busy ? psum_wr_addr : idx_t'(load.addr)),
        .wr_data(busy ? psum_wr_data : load.data),
        .rd_addr(psum_addr),
        .rd_data(psum_rd)
    );

endmodule

/* test/clk_gen.sv */
module clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;            // released off the edge
    end

endmodule

/* test/conv_pe_properties.sv */
module conv_pe_properties (
    input logic clk,
    input logic rst,
    input logic start,
    input logic reset_all,
    input logic start_rd_gen,
    input logic out_valid,
    input logic done
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;   // failed assertions so far

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("done held high for more than one cycle");
            fail_count++;
        end

    // reset_all is high only while the controller sits in idle
    a_idle_quiet: assert property (@(posedge clk) disable iff (rst) reset_all |-> !out_valid)
        else begin
            $error("out_valid high while the controller is idle");
            fail_count++;
        end

    a_start_seq: assert property (@(posedge clk) disable iff (rst)
        (start && reset_all) |-> ##2 start_rd_gen)
        else begin
            $error("start_rd_gen missing two cycles after start");
            fail_count++;
        end

endmodule

bind conv_pe conv_pe_properties i_props (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .reset_all   (reset_all),
    .start_rd_gen(start_rd_gen),
    .out_valid   (out_valid),
    .done        (done)
);

/* test/tb_conv_pe.sv */
`include "pe_cfg.svh"

module tb_conv_pe;
    timeunit 1ns;
    timeprecision 1ps;

    import pe_pkg::*;

    localparam int IF_LEN      = `IF_LEN;
    localparam int FILT_LEN    = `FILT_LEN;
    localparam int N_RANDOM    = 30;
    localparam int N_TESTS     = N_RANDOM + 7;
    localparam int LOAD_CYC    = 3 * IF_LEN + 2 * FILT_LEN;
    localparam int TIMEOUT_CYC = N_TESTS * (2 * IF_LEN * FILT_LEN + LOAD_CYC + 16) + 50;

    logic      clk;
    logic      rst;
    logic      load_en;
    load_t     load;
    logic      start;
    pass_cfg_t cfg;
    logic      out_valid;
    result_t   out;
    logic      done;

    integer seed = 32'he091_9c9b;

    // model copies of the scratchpads
    data_t ifm [2*IF_LEN];
    data_t flt [2*FILT_LEN];
    psum_t psm [IF_LEN];
    psum_t expected_q [$];

    clk_gen i_clk_gen (.clk(clk), .rst(rst));

    conv_pe i_conv_pe (
        .clk      (clk),
        .rst      (rst),
        .load_en  (load_en),
        .load     (load),
        .start    (start),
        .cfg      (cfg),
        .out_valid(out_valid),
        .out      (out),
        .done     (done)
    );

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_failure(input string msg);
        $display("%s (at %0t ns)", msg, $time);
        abort_run();
    endtask

    task automatic check_value(input string name, input psum_t expected, input psum_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic data_t pick_data(input bit extreme);
        if (!extreme) begin
            return data_t'($random(seed));
        end
        case ($unsigned($random(seed)) % 4)
            0:       return data_t'(-128);
            1:       return data_t'(127);
            2:       return data_t'(-1);
            default: return data_t'($random(seed));
        endcase
    endfunction

    function automatic psum_t pick_psum(input bit extreme);
        if (!extreme) begin
            return psum_t'($random(seed));
        end
        return ($random(seed) & 1) ? psum_t'(24'h7f_ffff) : psum_t'(24'h80_0000);
    endfunction

    task automatic load_word(input load_tgt_e tgt, input int addr, input psum_t value);
        @(posedge clk);
        #2;
        load_en     = 1'b1;
        load.target = tgt;
        load.addr   = if_addr_t'(addr);
        load.data   = value;
    endtask

    task automatic load_rows(input bit extreme);
        for (int i = 0; i < 2 * IF_LEN; i++) begin
            ifm[i] = pick_data(extreme);
            load_word(tgt_ifmap, i, psum_t'(ifm[i]));
        end
        for (int i = 0; i < 2 * FILT_LEN; i++) begin
            flt[i] = pick_data(extreme);
            load_word(tgt_filter, i, psum_t'(flt[i]));
        end
        for (int i = 0; i < IF_LEN; i++) begin
            psm[i] = pick_psum(extreme);
            load_word(tgt_psum, i, psm[i]);
        end
        @(posedge clk);
        #2;
        load_en = 1'b0;
    endtask

    task automatic build_expected(input pe_mode_e m, input int s);
        psum_t acc;
        expected_q.delete();
        if (m == just_add) begin
            for (int j = 0; j < IF_LEN; j++) begin
                expected_q.push_back(psm[j] + psum_t'(ifm[j]));
            end
        end else begin
            for (int j = 0; j <= (IF_LEN - FILT_LEN) / s; j++) begin
                acc = '0;
                for (int k = 0; k < FILT_LEN; k++) begin
                    acc += psum_t'(flt[k]) * psum_t'(ifm[j * s + k]);
                    if (m == conv_two_row) begin
                        acc += psum_t'(flt[FILT_LEN + k]) * psum_t'(ifm[IF_LEN + j * s + k]);
                    end
                end
                expected_q.push_back(acc);
            end
        end
    endtask

    task automatic run_pass(input pe_mode_e m, input int s);
        int got;
        int cyc;
        int last_cyc;
        bit finished;
        build_expected(m, s);
        @(posedge clk);
        #2;
        start      = 1'b1;
        cfg.mode   = m;
        cfg.stride = stride_t'(s);
        @(posedge clk);
        #2;
        start    = 1'b0;
        got      = 0;
        cyc      = 0;
        last_cyc = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk);   // outputs settled mid-cycle
            cyc++;
            if (out_valid) begin
                if (got >= expected_q.size()) begin
                    report_failure("out_valid seen beyond the expected number of results");
                end
                check_value("out.index", psum_t'(got), psum_t'(out.index));
                check_value("out.value", expected_q[got], out.value);
                got++;
                last_cyc = cyc;
            end
            if (done) begin
                check_value("result count at done", psum_t'(expected_q.size()), psum_t'(got));
                check_value("done cycles after last out_valid", psum_t'(1),
                            psum_t'(cyc - last_cyc));
                finished = 1'b1;
            end
        end
        repeat (3) begin
            @(negedge clk);
            if (out_valid || done) begin
                report_failure("out_valid or done seen after the pass ended");
            end
        end
        if (i_conv_pe.i_props.fail_count != 0) begin
            report_failure("a bound assertion failed during the pass");
        end
    endtask

    initial begin
        pe_mode_e m;
        int       s;
        bit       extreme;
        load_en = 1'b0;
        load    = '0;
        start   = 1'b0;
        cfg     = '0;
        while (rst !== 1'b0) begin
            @(posedge clk);
        end

        for (int st = 1; st <= `MAX_STRIDE; st++) begin
            load_rows(1'b0);
            run_pass(conv_row, st);
        end
        load_rows(1'b0);
        run_pass(conv_two_row, 1);
        load_rows(1'b0);
        run_pass(just_add, 1);
        load_rows(1'b1);          // saturated words
        run_pass(conv_two_row, 3);
        load_rows(1'b1);
        run_pass(just_add, 2);

        for (int t = 0; t < N_RANDOM; t++) begin
            m       = pe_mode_e'(2'($unsigned($random(seed)) % 3));
            s       = 1 + int'($unsigned($random(seed)) % `MAX_STRIDE);
            extreme = ($random(seed) & 3) == 0;
            load_rows(extreme);
            run_pass(m, s);
        end

        $display("TB PASSED");
        $finish;
    end

    // watchdog sized from the test count
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYC);
        abort_run();
    end

endmodule

/* build.f */
+incdir+verilog
verilog/pe_pkg.sv
verilog/pe_controller.sv
verilog/scratchpad.sv
verilog/addr_gen.sv
verilog/mac_unit.sv
verilog/conv_pe.sv
test/clk_gen.sv
test/conv_pe_properties.sv
test/tb_conv_pe.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_conv_pe -Mdir obj_dir -o sim_conv_pe -f build.f

./obj_dir/sim_conv_pe +verilator+error+limit+100 > sim.log 2>&1 || true

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
